//--- verilog.f
+incdir+hw
hw/zg_pkg.sv
hw/zg_frame_store.sv
hw/zg_anim_sequencer.sv
hw/zg_status_bars.sv
hw/zg_pixel_mux.sv
hw/zg_display_ctrl.sv
test/tb_clock.sv
test/tb_zg_display_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    -f verilog.f \
    --top-module tb_zg_display_ctrl \
    && ./obj_dir/Vtb_zg_display_ctrl | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_zg_display_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "zg_params.svh"

module tb_zg_display_ctrl;

    import zg_pkg::*;

    localparam int c_frame_bits  = 6;
    localparam int c_store_bytes = `ZG_FRAME_SLOTS * `ZG_DISPLAY_BYTES;
    localparam int c_bar_span    = `ZG_BAR_HI - `ZG_BAR_LO + 1;
    // a read driven after one edge shows on o_data three edges later
    localparam int c_latency     = 3;

    logic        clk;
    logic        arst_n;
    logic        load_we;
    store_addr_t load_addr;
    pixel_t      load_data;
    pet_state_t  state;
    byte_idx_t   byte_idx;
    stat_t       happiness;
    stat_t       hunger;
    stat_t       sleep;
    pixel_t      data;
    logic        frame_start;

    // model of the frame store and of the per-state frame counters
    pixel_t      image [0:c_store_bytes-1];
    int          ctr [0:7];
    pet_state_t  state_list [0:7];

    int          cycle;
    int          pulses;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    string       test_name;

    int          exp_due [$];
    pixel_t      exp_val [$];
    string       exp_name [$];

    tb_clock u_clock (
        .o_clk (clk)
    );

    zg_display_ctrl #(
        .p_frame_bits (c_frame_bits)
    ) UUT (
        .clk           (clk),
        .i_arst_n      (arst_n),
        .i_load_we     (load_we),
        .i_load_addr   (load_addr),
        .i_load_data   (load_data),
        .i_state       (state),
        .i_byte_idx    (byte_idx),
        .i_happiness   (happiness),
        .i_hunger      (hunger),
        .i_sleep       (sleep),
        .o_data        (data),
        .o_frame_start (frame_start)
    );

    // k indexes state_list, 0 is intro and 1 to 5 are the animated states
    function automatic int frame_count(input int k);
        case (k)
            1:       return `ZG_IDLE_FRAMES;
            2:       return `ZG_SLEEP_FRAMES;
            3:       return `ZG_EAT_FRAMES;
            4:       return `ZG_TEACH_FRAMES;
            5:       return `ZG_DEAD_FRAMES;
            default: return `ZG_INTRO_FRAMES;
        endcase
    endfunction

    function automatic int base_slot(input int k);
        case (k)
            1:       return `ZG_IDLE_BASE;
            2:       return `ZG_SLEEP_BASE;
            3:       return `ZG_EAT_BASE;
            4:       return `ZG_TEACH_BASE;
            5:       return `ZG_DEAD_BASE;
            default: return `ZG_INTRO_BASE;
        endcase
    endfunction

    function automatic pixel_t bar_model_byte(input int idx, input int h, input int hu,
                                              input int s);
        int row;
        int seg;
        int level;
        int upper;
        row   = idx / 8;
        seg   = idx % 8;
        level = -1;
        if (row >= 8 && row <= 12) begin
            level = h;
        end else if (row >= 18 && row <= 22) begin
            level = hu;
        end else if (row >= 28 && row <= 32) begin
            level = s;
        end
        if (level < 0 || seg < 1 || seg > 5) begin
            return 8'h00;
        end
        upper = 100 - 20 * seg + 10;
        if (level > upper) begin
            return 8'hEE;
        end else if (level > upper - 10) begin
            return 8'hE0;
        end
        return 8'h00;
    endfunction

    function automatic pixel_t expected_byte(input int k, input int idx, input int h,
                                             input int hu, input int s);
        int slot;
        if (k != 0 && idx >= `ZG_BAR_LO && idx <= `ZG_BAR_HI) begin
            return bar_model_byte(idx, h, hu, s);
        end
        slot = base_slot(k) + ctr[k[2:0]];
        return image[store_addr_t'(slot * `ZG_DISPLAY_BYTES + idx)];
    endfunction

    // uniform over the indices that lie outside the status panel
    function automatic int pick_image_idx();
        int idx;
        idx = $urandom_range(`ZG_DISPLAY_BYTES - 1 - c_bar_span, 0);
        if (idx >= `ZG_BAR_LO) begin
            idx = idx + c_bar_span;
        end
        return idx;
    endfunction

    function automatic int pick_stat();
        return $urandom_range(255, 0);
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        test_errors++;
        $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", name, what, expected, actual);
    endtask

    task automatic note_check();
        checks++;
        test_checks++;
    endtask

    task automatic flag_timeout(input string reason);
        if (!timed_out) begin
            $display("TIMEOUT in %s: %s", test_name, reason);
        end
        timed_out = 1'b1;
    endtask

    // one clock, then update the counter model and compare every read that is due
    task automatic next_cycle();
        @(posedge clk);
        #2;
        cycle++;
        if (frame_start) begin
            pulses++;
            for (int k = 0; k < 6; k++) begin
                ctr[k[2:0]] = (ctr[k[2:0]] + 1) % frame_count(k);
            end
        end
        while (exp_due.size() > 0 && exp_due[0] == cycle) begin
            note_check();
            if (data !== exp_val[0]) begin
                report_mismatch(exp_name[0], "o_data", 32'(exp_val[0]), 32'(data));
            end
            void'(exp_due.pop_front());
            void'(exp_val.pop_front());
            void'(exp_name.pop_front());
        end
    endtask

    task automatic drive_read(input int k, input int idx, input int h, input int hu,
                              input int s);
        load_we   = 1'b0;
        state     = state_list[k[2:0]];
        byte_idx  = byte_idx_t'(idx);
        happiness = stat_t'(h);
        hunger    = stat_t'(hu);
        sleep     = stat_t'(s);
        exp_due.push_back(cycle + c_latency);
        exp_val.push_back(expected_byte(k, idx, h, hu, s));
        exp_name.push_back(test_name);
    endtask

    task automatic drive_write(input int addr, input pixel_t value);
        load_we   = 1'b1;
        load_addr = store_addr_t'(addr);
        load_data = value;
        image[load_addr] = value;
    endtask

    task automatic drain_pending();
        int waited;
        waited  = 0;
        load_we = 1'b0;
        while (exp_due.size() > 0 && waited < c_latency + 4) begin
            next_cycle();
            waited++;
        end
        if (exp_due.size() > 0) begin
            flag_timeout("expected reads never came due");
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic close_test();
        drain_pending();
        tests_run++;
        if (test_errors > 0 || timed_out) begin
            tests_failed++;
        end
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    // keeps one state and reads random image bytes until n frame pulses have passed
    task automatic read_over_pulses(input int k, input int n);
        int start;
        int waited;
        int limit;
        start  = pulses;
        waited = 0;
        limit  = (n + 1) * (1 << c_frame_bits);
        while (pulses - start < n && waited < limit) begin
            drive_read(k, pick_image_idx(), pick_stat(), pick_stat(), pick_stat());
            next_cycle();
            waited++;
        end
        if (pulses - start < n) begin
            flag_timeout("o_frame_start pulses stopped");
        end
    endtask

    task automatic run_reset_state();
        int waited;
        start_test("reset_state");
        arst_n = 1'b0;
        next_cycle();
        next_cycle();
        note_check();
        if (data !== 8'h00) begin
            report_mismatch(test_name, "o_data in reset", 32'h0, 32'(data));
        end
        arst_n = 1'b1;
        note_check();
        if (data !== 8'h00 || frame_start !== 1'b0) begin
            report_mismatch(test_name, "o_data/o_frame_start", 32'h0, {23'd0, frame_start, data});
        end
        waited = 0;
        while (!frame_start && waited < 4 * (1 << c_frame_bits)) begin
            next_cycle();
            waited++;
        end
        if (!frame_start) begin
            flag_timeout("no o_frame_start pulse after reset");
        end else begin
            note_check();
            if (waited != (1 << c_frame_bits)) begin
                report_mismatch(test_name, "cycles to first pulse", 1 << c_frame_bits, waited);
            end
            next_cycle();
            note_check();
            if (frame_start !== 1'b0) begin
                report_mismatch(test_name, "pulse length", 32'h0, 32'(frame_start));
            end
        end
        close_test();
    endtask

    task automatic run_image_load_readback();
        start_test("image_load_readback");
        for (int a = 0; a < c_store_bytes; a++) begin
            drive_write(a, pixel_t'($urandom));
            next_cycle();
        end
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 48; n++) begin
                drive_read(k, pick_image_idx(), pick_stat(), pick_stat(), pick_stat());
                next_cycle();
            end
        end
        close_test();
    endtask

    task automatic run_animation_advance();
        int k;
        start_test("animation_advance");
        for (int r = 0; r < 3 && !timed_out; r++) begin
            k = $urandom_range(5, 1);
            read_over_pulses(k, frame_count(k) + 2);
        end
        close_test();
    endtask

    task automatic run_status_bars();
        int edge_vals [0:7];
        int k;
        int h;
        int hu;
        int s;
        int i1;
        int i2;
        start_test("status_bars");
        edge_vals = '{0, 10, 11, 90, 91, 80, 81, 255};
        for (int c = 0; c < 12; c++) begin
            k = $urandom_range(5, 1);
            if (c < 8) begin
                i1 = (c + 3) % 8;
                i2 = (c + 5) % 8;
                h  = edge_vals[c[2:0]];
                hu = edge_vals[i1[2:0]];
                s  = edge_vals[i2[2:0]];
            end else begin
                h  = pick_stat();
                hu = pick_stat();
                s  = pick_stat();
            end
            for (int idx = `ZG_BAR_LO; idx <= `ZG_BAR_HI; idx++) begin
                drive_read(k, idx, h, hu, s);
                next_cycle();
            end
        end
        close_test();
    endtask

    task automatic run_intro_ignores_bars();
        start_test("intro_ignores_bars");
        for (int idx = `ZG_BAR_LO; idx <= `ZG_BAR_HI; idx++) begin
            drive_read(0, idx, pick_stat(), pick_stat(), pick_stat());
            next_cycle();
        end
        close_test();
    endtask

    task automatic run_random_mix();
        start_test("random_mix");
        for (int n = 0; n < 3000; n++) begin
            drive_read($urandom_range(5, 0), $urandom_range(`ZG_DISPLAY_BYTES - 1, 0),
                       pick_stat(), pick_stat(), pick_stat());
            next_cycle();
        end
        close_test();
    endtask

    initial begin
        void'($urandom(32'h0ac7ac79));
        arst_n     = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        state      = INTRO;
        byte_idx   = '0;
        happiness  = '0;
        hunger     = '0;
        sleep      = '0;
        state_list = '{INTRO, IDLE, SLEEPING, EATING, TEACHING, DEAD, INTRO, INTRO};
        for (int k = 0; k < 8; k++) begin
            ctr[k[2:0]] = 0;
        end
        cycle        = 0;
        pulses       = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        run_reset_state();
        if (!timed_out) begin
            run_image_load_readback();
        end
        if (!timed_out) begin
            run_animation_advance();
        end
        if (!timed_out) begin
            run_status_bars();
        end
        if (!timed_out) begin
            run_intro_ignores_bars();
        end
        if (!timed_out) begin
            run_random_mix();
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int p_half_period = 10
) (
    output logic o_clk
);

    // free-running clock, 20 ns period with the default half period
    initial begin
        o_clk = 1'b0;
    end

    always #(p_half_period) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- hw/zg_display_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "zg_params.svh"

module zg_display_ctrl #(
    parameter int p_frame_bits = `ZG_FRAME_BITS
) (
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  wire logic           i_load_we,
    input  zg_pkg::store_addr_t i_load_addr,
    input  zg_pkg::pixel_t      i_load_data,
    input  zg_pkg::pet_state_t  i_state,
    input  zg_pkg::byte_idx_t   i_byte_idx,
    input  zg_pkg::stat_t       i_happiness,
    input  zg_pkg::stat_t       i_hunger,
    input  zg_pkg::stat_t       i_sleep,
    output zg_pkg::pixel_t      o_data,
    output logic                o_frame_start
);

    import zg_pkg::*;

    frame_slot_t slot;
    logic        in_bar_region;
    pixel_t      bar_byte;
    store_addr_t rd_addr;
    pixel_t      rd_data;

    zg_frame_store u_frame_store (
        .clk         (clk),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (rd_data)
    );

    zg_anim_sequencer #(
        .p_frame_bits (p_frame_bits)
    ) u_anim_sequencer (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_state       (i_state),
        .o_slot        (slot),
        .o_frame_start (o_frame_start)
    );

    zg_status_bars u_status_bars (
        .i_byte_idx      (i_byte_idx),
        .i_happiness     (i_happiness),
        .i_hunger        (i_hunger),
        .i_sleep         (i_sleep),
        .o_in_bar_region (in_bar_region),
        .o_bar_byte      (bar_byte)
    );

    // two register stages plus the store read, three clocks from index to byte
    zg_pixel_mux u_pixel_mux (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_state         (i_state),
        .i_byte_idx      (i_byte_idx),
        .i_slot          (slot),
        .i_in_bar_region (in_bar_region),
        .i_bar_byte      (bar_byte),
        .o_rd_addr       (rd_addr),
        .i_rd_data       (rd_data),
        .o_data          (o_data)
    );

endmodule

`default_nettype wire

//--- hw/zg_pixel_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "zg_params.svh"

module zg_pixel_mux (
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  zg_pkg::pet_state_t  i_state,
    input  zg_pkg::byte_idx_t   i_byte_idx,
    input  zg_pkg::frame_slot_t i_slot,
    input  wire logic           i_in_bar_region,
    input  zg_pkg::pixel_t      i_bar_byte,
    output zg_pkg::store_addr_t o_rd_addr,
    input  zg_pkg::pixel_t      i_rd_data,
    output zg_pkg::pixel_t      o_data
);

    import zg_pkg::*;

    // stage 1 holds the store address and the bar decision
    store_addr_t rd_addr_q;
    logic        use_bar_q;
    pixel_t      bar_byte_q;

    // stage 2 delays the bar path to line up with the store read
    logic        use_bar_q2;
    pixel_t      bar_byte_q2;

    logic        use_bar;

    // the intro screen has no status panel and shows its image everywhere
    assign use_bar = (i_state != INTRO) && i_in_bar_region;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_addr_q   <= '0;
            use_bar_q   <= 1'b0;
            bar_byte_q  <= '0;
            use_bar_q2  <= 1'b0;
            bar_byte_q2 <= '0;
        end else begin
            // slot * 1024 + byte index
            rd_addr_q   <= {i_slot, i_byte_idx};
            use_bar_q   <= use_bar;
            bar_byte_q  <= i_bar_byte;
            use_bar_q2  <= use_bar_q;
            bar_byte_q2 <= bar_byte_q;
        end
    end

    assign o_rd_addr = rd_addr_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_data <= '0;
        end else if (use_bar_q2) begin
            o_data <= bar_byte_q2;
        end else begin
            o_data <= i_rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/zg_status_bars.sv
`timescale 1ns/100ps
`default_nettype none

`include "zg_params.svh"

module zg_status_bars (
    input  zg_pkg::byte_idx_t i_byte_idx,
    input  zg_pkg::stat_t     i_happiness,
    input  zg_pkg::stat_t     i_hunger,
    input  zg_pkg::stat_t     i_sleep,
    output logic              o_in_bar_region,
    output zg_pkg::pixel_t    o_bar_byte
);

    import zg_pkg::*;

    // a row is one line of 8 bytes, the segment is the byte within that line
    logic [`ZG_BYTE_BITS-4:0] row;
    logic [2:0]               seg;
    logic                     on_gauge;
    logic                     on_seg;
    stat_t                    level;
    int                       upper_thr;
    int                       lower_thr;
    pixel_t                   bar_byte;

    assign row = i_byte_idx[`ZG_BYTE_BITS-1:3];
    assign seg = i_byte_idx[2:0];

    assign o_in_bar_region = (i_byte_idx >= byte_idx_t'(`ZG_BAR_LO)) &&
                             (i_byte_idx <= byte_idx_t'(`ZG_BAR_HI));

    // pick the gauge from the row band
    always_comb begin
        on_gauge = 1'b1;
        level    = '0;
        if (int'(row) >= `ZG_HAPPY_ROW && int'(row) < `ZG_HAPPY_ROW + `ZG_BAR_ROWS) begin
            level = i_happiness;
        end else if (int'(row) >= `ZG_HUNGER_ROW &&
                     int'(row) < `ZG_HUNGER_ROW + `ZG_BAR_ROWS) begin
            level = i_hunger;
        end else if (int'(row) >= `ZG_SLEEP_ROW &&
                     int'(row) < `ZG_SLEEP_ROW + `ZG_BAR_ROWS) begin
            level = i_sleep;
        end else begin
            on_gauge = 1'b0;
        end
    end

    // segments 1 to 5 carry the bar, 0, 6 and 7 are the gaps around it
    assign on_seg = (seg >= 3'd1) && (int'(seg) <= `ZG_BAR_SEGMENTS);

    // segment 1 covers 80..90, segment 5 covers 0..10
    assign upper_thr = `ZG_THRESH_TOP - 2 * `ZG_THRESH_STEP * (int'(seg) - 1);
    assign lower_thr = upper_thr - `ZG_THRESH_STEP;

    always_comb begin
        bar_byte = '0;
        if (o_in_bar_region && on_gauge && on_seg) begin
            if (int'(level) > upper_thr) begin
                bar_byte = `ZG_SEG_FULL;
            end else if (int'(level) > lower_thr) begin
                bar_byte = `ZG_SEG_HALF;
            end
        end
    end

    assign o_bar_byte = bar_byte;

endmodule

`default_nettype wire

//--- hw/zg_anim_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "zg_params.svh"

module zg_anim_sequencer #(
    parameter int p_frame_bits = `ZG_FRAME_BITS
) (
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  zg_pkg::pet_state_t  i_state,
    output zg_pkg::frame_slot_t o_slot,
    output logic                o_frame_start
);

    import zg_pkg::*;

    // intro has a single frame, so only the five animated states keep a counter
    localparam int c_anims = 5;
    localparam int c_frames [c_anims] = '{
        `ZG_IDLE_FRAMES,
        `ZG_SLEEP_FRAMES,
        `ZG_EAT_FRAMES,
        `ZG_TEACH_FRAMES,
        `ZG_DEAD_FRAMES
    };

    logic [p_frame_bits-1:0] frame_timer;
    logic                    timer_wrap;
    logic [2:0]              frame_idx [c_anims];

    assign timer_wrap = (frame_timer == {p_frame_bits{1'b1}});

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            frame_timer   <= '0;
            o_frame_start <= 1'b0;
        end else begin
            frame_timer   <= frame_timer + 1'b1;
            o_frame_start <= timer_wrap;
        end
    end

    // all animations step together, each wrapping at its own length
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < c_anims; i++) begin
                frame_idx[i] <= '0;
            end
        end else if (timer_wrap) begin
            for (int i = 0; i < c_anims; i++) begin
                if (int'(frame_idx[i]) == c_frames[i] - 1) begin
                    frame_idx[i] <= '0;
                end else begin
                    frame_idx[i] <= frame_idx[i] + 3'd1;
                end
            end
        end
    end

    // absolute slot of the frame shown for the current state
    always_comb begin
        case (i_state)
            INTRO:    o_slot = frame_slot_t'(`ZG_INTRO_BASE);
            IDLE:     o_slot = frame_slot_t'(`ZG_IDLE_BASE) + frame_slot_t'(frame_idx[0]);
            SLEEPING: o_slot = frame_slot_t'(`ZG_SLEEP_BASE) + frame_slot_t'(frame_idx[1]);
            EATING:   o_slot = frame_slot_t'(`ZG_EAT_BASE) + frame_slot_t'(frame_idx[2]);
            TEACHING: o_slot = frame_slot_t'(`ZG_TEACH_BASE) + frame_slot_t'(frame_idx[3]);
            DEAD:     o_slot = frame_slot_t'(`ZG_DEAD_BASE) + frame_slot_t'(frame_idx[4]);
            // the last slot is never filled by an animation and stays blank
            default:  o_slot = frame_slot_t'(`ZG_FRAME_SLOTS - 1);
        endcase
    end

endmodule

`default_nettype wire

//--- hw/zg_frame_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "zg_params.svh"

module zg_frame_store (
    input  wire                 clk,
    input  wire logic           i_load_we,
    input  zg_pkg::store_addr_t i_load_addr,
    input  zg_pkg::pixel_t      i_load_data,
    input  zg_pkg::store_addr_t i_rd_addr,
    output zg_pkg::pixel_t      o_rd_data
);

    import zg_pkg::*;

    localparam int c_depth = `ZG_FRAME_SLOTS * `ZG_DISPLAY_BYTES;

    // every animation frame back to back, one 1024 byte image per slot
    pixel_t mem [0:c_depth-1];

    always_ff @(posedge clk) begin
        if (i_load_we) begin
            mem[i_load_addr] <= i_load_data;
        end
    end

    // registered read, a read that hits the address being written sees the old byte
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/zg_pkg.sv
`default_nettype none

`include "zg_params.svh"

package zg_pkg;

    // one-hot pet states, intro is the all-zero code
    typedef enum logic [4:0] {
        INTRO    = 5'b00000,
        IDLE     = 5'b00001,
        SLEEPING = 5'b00010,
        EATING   = 5'b00100,
        TEACHING = 5'b01000,
        DEAD     = 5'b10000
    } pet_state_t;

    // index of a byte inside one display image
    typedef logic [`ZG_BYTE_BITS-1:0] byte_idx_t;

    typedef logic [7:0] pixel_t;

    // stat level, 0 to 255
    typedef logic [7:0] stat_t;

    // absolute frame number inside the frame store
    typedef logic [$clog2(`ZG_FRAME_SLOTS)-1:0] frame_slot_t;

    typedef logic [`ZG_ADDR_BITS-1:0] store_addr_t;

endpackage

`default_nettype wire

//--- hw/zg_params.svh
`ifndef ZG_PARAMS_SVH
`define ZG_PARAMS_SVH

// display geometry, 128x64 pixels sent as 1024 bytes of 8 vertical pixels
`define ZG_BYTE_BITS      10
`define ZG_DISPLAY_BYTES  1024

// frame store holds 32 full images, addressed as slot * 1024 + byte index
`define ZG_FRAME_SLOTS    32
`define ZG_ADDR_BITS      15

// default frame timer width, one animation step every 2^23 clocks
`define ZG_FRAME_BITS     23

// frames per pet state
`define ZG_INTRO_FRAMES   1
`define ZG_IDLE_FRAMES    6
`define ZG_SLEEP_FRAMES   4
`define ZG_EAT_FRAMES     5
`define ZG_TEACH_FRAMES   7
`define ZG_DEAD_FRAMES    8

// first slot of each animation in the frame store
`define ZG_INTRO_BASE     0
`define ZG_IDLE_BASE      1
`define ZG_SLEEP_BASE     7
`define ZG_EAT_BASE       11
`define ZG_TEACH_BASE     16
`define ZG_DEAD_BASE      23

// status panel limits, as byte indices
`define ZG_BAR_LO         65
`define ZG_BAR_HI         261

// first row (byte index / 8) of each gauge
`define ZG_HAPPY_ROW      8
`define ZG_HUNGER_ROW     18
`define ZG_SLEEP_ROW      28

`define ZG_BAR_ROWS       5
`define ZG_BAR_SEGMENTS   5

// segment patterns, a full block or only its upper half
`define ZG_SEG_FULL       8'hEE
`define ZG_SEG_HALF       8'hE0

// segment 1 lights fully above 90, every next segment 20 lower
`define ZG_THRESH_TOP     90
`define ZG_THRESH_STEP    10

`endif
